// ==== hdl/dcache_cfg.svh ====
/* Geometry of the direct-mapped data cache.
   Included by the package and by every module that sizes a field from it. */

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Width of one data word in bits
`define DCACHE_XLEN 32

// Number of lines in the single way
`define DCACHE_LINES 16

// Words held by one line
`define DCACHE_WORDS 4

// Tag width left over from a 32-bit byte address after offset and index
`define DCACHE_TAGLEN 24

`endif

// ==== hdl/dcachePkg.sv ====
/* Data types shared by the cache controller, the cache way and the testbench.
   Referenced by scoped name only. */

`include "dcache_cfg.svh"

package dcachePkg;

  // One data word as seen by the CPU and stored in the data RAMs
  typedef logic [`DCACHE_XLEN-1:0] wordT;

  // Upper address bits kept per line
  typedef logic [`DCACHE_TAGLEN-1:0] tagT;

  // Selects one of the lines of the way
  typedef logic [$clog2(`DCACHE_LINES)-1:0] indexT;

  // Position of a word inside its line
  typedef logic [$clog2(`DCACHE_WORDS)-1:0] wordSelT;

  // A whole line with word 0 at the lowest address
  typedef wordT [`DCACHE_WORDS-1:0] blockT;

  // Operations a CPU request can ask for
  typedef enum logic [1:0] {
    opRead,
    opWrite,
    opFlush
  } cacheOpT;

endpackage

// ==== hdl/cacheArrayIf.sv ====
/* Access path from the cache controller to the storage of the way.
   The controller uses modport ctrl and the way uses modport way. */

`timescale 1ns/1ps
`include "dcache_cfg.svh"

interface cacheArrayIf;

  // Read and data write index, plus the index for valid and dirty updates
  dcachePkg::indexT adr;
  dcachePkg::indexT wAdr;

  // Data write controls, one enable bit per word of the line
  logic writeEnable;
  logic [`DCACHE_WORDS-1:0] wordEnable;
  dcachePkg::blockT writeData;

  // Tag write controls
  logic tagWriteEnable;
  dcachePkg::tagT writeTag;

  // Status bit updates, only applied together with writeEnable
  logic setValid;
  logic clearValid;
  logic setDirty;
  logic clearDirty;

  // Registered read results for the line at adr
  dcachePkg::blockT readData;
  dcachePkg::tagT readTag;
  logic valid;
  logic dirty;

  modport ctrl (
    output adr, wAdr, writeEnable, wordEnable, writeData, tagWriteEnable, writeTag,
    output setValid, clearValid, setDirty, clearDirty,
    input readData, readTag, valid, dirty
  );

  modport way (
    input adr, wAdr, writeEnable, wordEnable, writeData, tagWriteEnable, writeTag,
    input setValid, clearValid, setDirty, clearDirty,
    output readData, readTag, valid, dirty
  );

endinterface

// ==== hdl/sram1rw.sv ====
/* Single-port synchronous RAM with one cycle of read latency.
   The entry type is a parameter so data words and tags share this model. */

`timescale 1ns/1ps

module sram1rw #(
  parameter type entryT = logic [31:0],
  parameter int depth = 16
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] adr,
  input  logic                     writeEnable,
  input  entryT                    writeData,
  output entryT                    readData
);

  // Storage array
  entryT mem [depth];

  // Write-first behaviour
  // A write shows its new value on the read port in the following cycle
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[adr] <= writeData;
      readData <= writeData;
    end else begin
      readData <= mem[adr];
    end
  end

endmodule

// ==== hdl/dcacheMem.sv ====
/* Storage for the single way of the cache: data words, tags, valid and dirty bits.
   Every read is registered; status bits follow the same write-first rule as the RAMs. */

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcacheMem (
  input logic clk,
  input logic reset,
  cacheArrayIf.way arr
);

  // One status bit per line
  logic [`DCACHE_LINES-1:0] validBits;
  logic [`DCACHE_LINES-1:0] dirtyBits;

  // Status vectors with this cycle's update already applied
  logic [`DCACHE_LINES-1:0] validNext;
  logic [`DCACHE_LINES-1:0] dirtyNext;

  ////////////////////////////////////////
  // Data and tag RAMs
  ////////////////////////////////////////

  // Each word of the line lives in its own RAM so single words can be written
  for (genvar w = 0; w < `DCACHE_WORDS; w++) begin : gWord
    sram1rw #(
      .entryT(dcachePkg::wordT),
      .depth(`DCACHE_LINES)
    ) dataRam (
      .clk(clk),
      .adr(arr.adr),
      .writeEnable(arr.writeEnable & arr.wordEnable[w]),
      .writeData(arr.writeData[w]),
      .readData(arr.readData[w])
    );
  end

  // Tag RAM shares the read index with the data RAMs
  sram1rw #(
    .entryT(dcachePkg::tagT),
    .depth(`DCACHE_LINES)
  ) tagRam (
    .clk(clk),
    .adr(arr.adr),
    .writeEnable(arr.tagWriteEnable),
    .writeData(arr.writeTag),
    .readData(arr.readTag)
  );

  ////////////////////////////////////////
  // Valid and dirty bits
  ////////////////////////////////////////

  // Set wins over clear when both are asked for
  always_comb begin
    validNext = validBits;
    dirtyNext = dirtyBits;
    if (arr.writeEnable) begin
      if (arr.setValid) begin
        validNext[arr.wAdr] = 1'b1;
      end else if (arr.clearValid) begin
        validNext[arr.wAdr] = 1'b0;
      end
      if (arr.setDirty) begin
        dirtyNext[arr.wAdr] = 1'b1;
      end else if (arr.clearDirty) begin
        dirtyNext[arr.wAdr] = 1'b0;
      end
    end
  end

  // Read ports take the updated vectors, so a fill is visible on the next lookup
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      arr.valid <= 1'b0;
      arr.dirty <= 1'b0;
    end else begin
      validBits <= validNext;
      dirtyBits <= dirtyNext;
      arr.valid <= validNext[arr.adr];
      arr.dirty <= dirtyNext[arr.adr];
    end
  end

endmodule

// ==== hdl/dcacheCtrl.sv ====
/* Controller of the write-back cache: tag lookup, victim write-back, line fill and flush.
   Takes one CPU request at a time and talks to the backing store in whole lines. */

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcacheCtrl (
  input  logic                clk,
  input  logic                reset,
  // CPU side
  input  logic                reqValid,
  input  dcachePkg::cacheOpT  reqOp,
  input  logic [31:0]         reqAdr,
  input  dcachePkg::wordT     reqWData,
  output logic                reqReady,
  output logic                respValid,
  output dcachePkg::wordT     respData,
  // Memory side with addresses that count whole lines
  output logic                memReqValid,
  output logic                memWrite,
  output logic [$bits(dcachePkg::tagT)+$bits(dcachePkg::indexT)-1:0] memAdr,
  output dcachePkg::blockT    memWData,
  input  logic                memReqReady,
  input  logic                memRespValid,
  input  dcachePkg::blockT    memRData,
  // Way access
  cacheArrayIf.ctrl           arr
);

  // Field positions inside a byte address
  localparam int byteBits = $clog2(`DCACHE_XLEN / 8);
  localparam int selBits = $bits(dcachePkg::wordSelT);
  localparam int idxBits = $bits(dcachePkg::indexT);
  localparam int tagLsb = byteBits + selBits + idxBits;

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stWriteBack,
    stFillReq,
    stFillWait
  } stateT;

  stateT state;
  stateT stateNext;

  // Accepted request that is held until its response
  dcachePkg::cacheOpT opQ;
  dcachePkg::tagT tagQ;
  dcachePkg::indexT indexQ;
  dcachePkg::wordSelT selQ;
  dcachePkg::wordT wDataQ;

  logic accept;
  logic hit;
  logic doResp;
  logic loadRead;

  assign reqReady = (state == stIdle);
  assign accept = reqValid & reqReady;

  // Tag and valid are compared the cycle after the read was issued
  assign hit = arr.valid & (arr.readTag == tagQ);

  // Read the line of an incoming request right away, otherwise stay on the latched line
  assign arr.adr = (state == stIdle) ? reqAdr[byteBits+selBits +: idxBits] : indexQ;
  assign arr.wAdr = indexQ;
  assign arr.writeTag = tagQ;

  ////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////

  // A write-back sends the victim line under its stored tag
  assign memReqValid = (state == stWriteBack) | (state == stFillReq);
  assign memWrite = (state == stWriteBack);
  assign memAdr = (state == stWriteBack) ? {arr.readTag, indexQ} : {tagQ, indexQ};
  // The way keeps reading the same line, so the victim data holds still under back-pressure
  assign memWData = arr.readData;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb begin
    stateNext = state;
    doResp = 1'b0;
    loadRead = 1'b0;
    arr.writeEnable = 1'b0;
    arr.wordEnable = '0;
    arr.writeData = {`DCACHE_WORDS{wDataQ}};
    arr.tagWriteEnable = 1'b0;
    arr.setValid = 1'b0;
    arr.clearValid = 1'b0;
    arr.setDirty = 1'b0;
    arr.clearDirty = 1'b0;
    case (state)
      stIdle: begin
        if (reqValid) begin
          stateNext = stLookup;
        end
      end
      stLookup: begin
        if (opQ == dcachePkg::opFlush) begin
          if (hit && arr.dirty) begin
            stateNext = stWriteBack;
          end else begin
            // Clean match is dropped at once, no match only needs the acknowledge
            arr.writeEnable = hit;
            arr.clearValid = 1'b1;
            arr.clearDirty = 1'b1;
            doResp = 1'b1;
            stateNext = stIdle;
          end
        end else if (hit) begin
          if (opQ == dcachePkg::opWrite) begin
            arr.writeEnable = 1'b1;
            arr.wordEnable[selQ] = 1'b1;
            arr.setDirty = 1'b1;
          end else begin
            loadRead = 1'b1;
          end
          doResp = 1'b1;
          stateNext = stIdle;
        end else if (arr.valid && arr.dirty) begin
          stateNext = stWriteBack;
        end else begin
          stateNext = stFillReq;
        end
      end
      stWriteBack: begin
        // The write is complete at the handshake
        if (memReqReady) begin
          if (opQ == dcachePkg::opFlush) begin
            arr.writeEnable = 1'b1;
            arr.clearValid = 1'b1;
            arr.clearDirty = 1'b1;
            doResp = 1'b1;
            stateNext = stIdle;
          end else begin
            stateNext = stFillReq;
          end
        end
      end
      stFillReq: begin
        if (memReqReady) begin
          stateNext = stFillWait;
        end
      end
      stFillWait: begin
        // Whole line, tag and status land together, then the lookup is repeated
        if (memRespValid) begin
          arr.writeEnable = 1'b1;
          arr.wordEnable = '1;
          arr.writeData = memRData;
          arr.tagWriteEnable = 1'b1;
          arr.setValid = 1'b1;
          arr.clearDirty = 1'b1;
          stateNext = stLookup;
        end
      end
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stIdle;
      respValid <= 1'b0;
    end else begin
      state <= stateNext;
      respValid <= doResp;
    end
  end

  // Request fields split from the byte address on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      opQ <= reqOp;
      tagQ <= reqAdr[tagLsb +: $bits(dcachePkg::tagT)];
      indexQ <= reqAdr[byteBits+selBits +: idxBits];
      selQ <= reqAdr[byteBits +: selBits];
      wDataQ <= reqWData;
    end
  end

  // Read data goes out with the response pulse
  always_ff @(posedge clk) begin
    if (loadRead) begin
      respData <= arr.readData[selQ];
    end
  end

endmodule

// ==== hdl/dcache.sv ====
/* Top level of the data cache with plain CPU and memory ports.
   Joins the controller to the storage of its single way. */

`timescale 1ns/1ps

module dcache (
  input  logic                clk,
  input  logic                reset,
  // CPU side
  input  logic                reqValid,
  input  dcachePkg::cacheOpT  reqOp,
  input  logic [31:0]         reqAdr,
  input  dcachePkg::wordT     reqWData,
  output logic                reqReady,
  output logic                respValid,
  output dcachePkg::wordT     respData,
  // Memory side
  output logic                memReqValid,
  output logic                memWrite,
  output logic [$bits(dcachePkg::tagT)+$bits(dcachePkg::indexT)-1:0] memAdr,
  output dcachePkg::blockT    memWData,
  input  logic                memReqReady,
  input  logic                memRespValid,
  input  dcachePkg::blockT    memRData
);

  // Path between the controller and the way
  cacheArrayIf arr ();

  dcacheCtrl ctrl (
    .clk(clk),
    .reset(reset),
    .reqValid(reqValid),
    .reqOp(reqOp),
    .reqAdr(reqAdr),
    .reqWData(reqWData),
    .reqReady(reqReady),
    .respValid(respValid),
    .respData(respData),
    .memReqValid(memReqValid),
    .memWrite(memWrite),
    .memAdr(memAdr),
    .memWData(memWData),
    .memReqReady(memReqReady),
    .memRespValid(memRespValid),
    .memRData(memRData),
    .arr(arr.ctrl)
  );

  // Data, tag and status storage
  dcacheMem way (
    .clk(clk),
    .reset(reset),
    .arr(arr.way)
  );

endmodule

// ==== bench/memModel.sv ====
/* Backing store for the cache testbench, moved in whole lines with random handshake delays.
   Unwritten words read as their byte address xor a fixed pattern; traffic is counted. */

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module memModel #(
  parameter int lineBits = `DCACHE_TAGLEN + $clog2(`DCACHE_LINES)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 memReqValid,
  input  logic                 memWrite,
  input  logic [lineBits-1:0]  memAdr,
  input  dcachePkg::blockT     memWData,
  output logic                 memReqReady,
  output logic                 memRespValid,
  output dcachePkg::blockT     memRData,
  output int                   readCount,
  output int                   writeCount,
  output int                   writesBeforeRead,
  output logic [lineBits-1:0]  lastWriteAdr,
  output dcachePkg::blockT     lastWriteLine
);

  // Sparse store of every word written back so far, keyed by byte address
  dcachePkg::wordT store [logic [31:0]];
  integer seed;
  int unsigned delay;

  function automatic logic [31:0] wordAddress(input logic [lineBits-1:0] line, input int w);
    return {line, 2'(w), 2'b00};
  endfunction

  function automatic dcachePkg::wordT fetchWord(input logic [31:0] adr);
    if (store.exists(adr)) begin
      return store[adr];
    end
    return adr ^ 32'hA5A5_0000;
  endfunction

  // Wait 0 to 3 cycles, staying on the drive phase just after the rising edge
  task automatic randomWait();
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Serves one request; the cache holds its values until the handshake
  task automatic serveRequest();
    logic isWrite;
    randomWait();
    isWrite = memWrite;
    memReqReady = 1'b1;
    if (isWrite) begin
      for (int w = 0; w < `DCACHE_WORDS; w++) begin
        store[wordAddress(memAdr, w)] = memWData[w];
      end
      writeCount++;
      lastWriteAdr = memAdr;
      lastWriteLine = memWData;
    end else begin
      readCount++;
      writesBeforeRead = writeCount;
      for (int w = 0; w < `DCACHE_WORDS; w++) begin
        memRData[w] = fetchWord(wordAddress(memAdr, w));
      end
    end
    @(posedge clk);
    #1;
    memReqReady = 1'b0;
    if (!isWrite) begin
      // The line comes back as a single response pulse
      randomWait();
      memRespValid = 1'b1;
      @(posedge clk);
      #1;
      memRespValid = 1'b0;
    end
  endtask

  initial begin
    seed = 32'h310b_02aa;
    memReqReady = 1'b0;
    memRespValid = 1'b0;
    memRData = '0;
    readCount = 0;
    writeCount = 0;
    writesBeforeRead = 0;
    lastWriteAdr = '0;
    lastWriteLine = '0;
    @(negedge reset);
    forever begin
      if (memReqValid) begin
        serveRequest();
      end else begin
        @(posedge clk);
        #1;
      end
    end
  end

endmodule

// ==== bench/dcacheTb.sv ====
/* Testbench for the write-back data cache against a flat word-map reference.
   Runs directed hit, miss, victim and flush cases, then a random mix of requests. */

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcacheTb;

  localparam int lineBits = `DCACHE_TAGLEN + $clog2(`DCACHE_LINES);
  // Ten directed requests plus the random mix
  localparam int numRequests = 310;

  logic clk = 1'b0;
  logic reset;
  logic reqValid;
  dcachePkg::cacheOpT reqOp;
  logic [31:0] reqAdr;
  dcachePkg::wordT reqWData;
  logic reqReady;
  logic respValid;
  dcachePkg::wordT respData;
  logic memReqValid;
  logic memWrite;
  logic [lineBits-1:0] memAdr;
  dcachePkg::blockT memWData;
  logic memReqReady;
  logic memRespValid;
  dcachePkg::blockT memRData;
  int readCount;
  int writeCount;
  int writesBeforeRead;
  logic [lineBits-1:0] lastWriteAdr;
  dcachePkg::blockT lastWriteLine;

  // Reference contents where only words written by the CPU are kept
  dcachePkg::wordT refMem [logic [31:0]];
  integer seed;
  logic pending = 1'b0;

  always #4 clk = ~clk;

  dcache dut (
    .clk(clk), .reset(reset),
    .reqValid(reqValid), .reqOp(reqOp), .reqAdr(reqAdr), .reqWData(reqWData),
    .reqReady(reqReady), .respValid(respValid), .respData(respData),
    .memReqValid(memReqValid), .memWrite(memWrite), .memAdr(memAdr), .memWData(memWData),
    .memReqReady(memReqReady), .memRespValid(memRespValid), .memRData(memRData)
  );

  memModel mem (
    .clk(clk), .reset(reset),
    .memReqValid(memReqValid), .memWrite(memWrite), .memAdr(memAdr), .memWData(memWData),
    .memReqReady(memReqReady), .memRespValid(memRespValid), .memRData(memRData),
    .readCount(readCount), .writeCount(writeCount), .writesBeforeRead(writesBeforeRead),
    .lastWriteAdr(lastWriteAdr), .lastWriteLine(lastWriteLine)
  );

  task automatic reportMismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic dcachePkg::wordT expectedWord(input logic [31:0] adr);
    if (refMem.exists(adr)) begin
      return refMem[adr];
    end
    return adr ^ 32'hA5A5_0000;
  endfunction

  // One CPU request from offer to response
  // Latency counts cycles after the handshake
  task automatic access(input dcachePkg::cacheOpT op, input logic [31:0] adr,
                        input dcachePkg::wordT data, output int latency);
    dcachePkg::wordT want;
    want = expectedWord(adr);
    reqValid = 1'b1;
    reqOp = op;
    reqAdr = adr;
    reqWData = data;
    @(negedge clk);
    while (!reqReady) @(negedge clk);
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!respValid);
    if (op == dcachePkg::opRead) begin
      assert (respData == want)
        else reportMismatch($sformatf("read %h gave %h, expected %h", adr, respData, want));
    end else if (op == dcachePkg::opWrite) begin
      refMem[adr] = data;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic expectTraffic(input int reads0, input int writes0, input int reads,
                               input int writes, input string what);
    assert (readCount == reads0 + reads && writeCount == writes0 + writes)
      else reportMismatch($sformatf("%s: %0d memory reads and %0d writes, expected %0d and %0d",
                                    what, readCount - reads0, writeCount - writes0,
                                    reads, writes));
  endtask

  // A new request may only be taken once the previous one has responded
  always @(negedge clk) begin
    if (!reset) begin
      if (respValid) begin
        assert (pending) else reportMismatch("respValid without an open request");
        pending = 1'b0;
      end
      assert (!(pending && reqReady)) else reportMismatch("reqReady high with a request open");
      if (reqValid && reqReady) begin
        pending = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int lat;
    int r0;
    int w0;
    int unsigned pick;
    int unsigned opSel;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] adr;
    dcachePkg::cacheOpT op;
    seed = 32'h310b_02aa;
    reset = 1'b1;
    reqValid = 1'b0;
    reqOp = dcachePkg::opRead;
    reqAdr = '0;
    reqWData = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (reqReady && !respValid && !memReqValid)
      else reportMismatch("handshake outputs wrong after reset");
    @(posedge clk);
    #1;

    // A and B share index 3 and word 1 but differ in tag
    a = 32'h0000_1234;
    b = 32'h0000_2234;

    // Cold read fills the line from memory
    r0 = readCount;
    w0 = writeCount;
    access(dcachePkg::opRead, a, '0, lat);
    expectTraffic(r0, w0, 1, 0, "first read");

    // Hits stay inside the cache and answer in two cycles
    access(dcachePkg::opWrite, a, 32'hDEAD_BEEF, lat);
    assert (lat == 2) else reportMismatch($sformatf("write hit latency %0d", lat));
    access(dcachePkg::opRead, a, '0, lat);
    assert (lat == 2) else reportMismatch($sformatf("read hit latency %0d", lat));
    expectTraffic(r0 + 1, w0, 0, 0, "write then read hit");

    // Conflict miss writes the dirty victim back before the fill
    r0 = readCount;
    w0 = writeCount;
    access(dcachePkg::opRead, b, '0, lat);
    expectTraffic(r0, w0, 1, 1, "conflict miss");
    assert (writesBeforeRead == w0 + 1) else reportMismatch("fill issued before write-back");
    assert (lastWriteAdr == a[31:4] && lastWriteLine[a[3:2]] == 32'hDEAD_BEEF)
      else reportMismatch($sformatf("victim line %h word %h", lastWriteAdr,
                                    lastWriteLine[a[3:2]]));
    access(dcachePkg::opRead, a, '0, lat);

    // Dirty flush writes back; clean and absent flushes stay quiet
    access(dcachePkg::opWrite, a, 32'h1111_2222, lat);
    r0 = readCount;
    w0 = writeCount;
    access(dcachePkg::opFlush, a, '0, lat);
    expectTraffic(r0, w0, 0, 1, "dirty flush");
    assert (lastWriteAdr == a[31:4] && lastWriteLine[a[3:2]] == 32'h1111_2222)
      else reportMismatch($sformatf("flushed line %h word %h", lastWriteAdr,
                                    lastWriteLine[a[3:2]]));
    access(dcachePkg::opRead, a, '0, lat);
    expectTraffic(r0, w0, 1, 1, "read after flush");
    access(dcachePkg::opFlush, a, '0, lat);
    access(dcachePkg::opFlush, 32'h0000_7770, '0, lat);
    expectTraffic(r0, w0, 1, 1, "clean and absent flush");

    // 64 addresses over four tags, four lines and four words
    repeat (300) begin
      pick = $unsigned($random(seed));
      opSel = $unsigned($random(seed)) % 3;
      adr = {22'h000400, pick[5:4], 2'b00, pick[3:2], pick[1:0], 2'b00};
      op = (opSel == 0) ? dcachePkg::opRead :
           (opSel == 1) ? dcachePkg::opWrite : dcachePkg::opFlush;
      access(op, adr, $random(seed), lat);
    end

    $display("All tests passed!");
    $finish;
  end

  // Watchdog sized from 40 cycles per request
  initial begin
    #(numRequests * 40 * 8);
    $display("Timeout: the cache did not finish all requests in time");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/dcachePkg.sv
hdl/cacheArrayIf.sv
hdl/sram1rw.sv
hdl/dcacheMem.sv
hdl/dcacheCtrl.sv
hdl/dcache.sv
bench/memModel.sv
bench/dcacheTb.sv

// ==== Makefile ====
# Verilator flow for the data cache and its testbench

OBJDIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module dcache

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
		--top-module dcacheTb --Mdir $(OBJDIR) -o simv
	out="$$($(OBJDIR)/simv 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJDIR)
